//--- verilog/dcache_defs.svh
`ifndef DCACHE_DEFS_SVH
`define DCACHE_DEFS_SVH

// ******************************
// Cache geometry
// ******************************
`define DC_WAYS        2
`define DC_SETS        16
`define DC_LINE_WORDS  4
`define DC_LINE_W      (`DC_LINE_WORDS * 32)

// ******************************
// Byte address fields
// ******************************
`define DC_OFFSET_W    4
`define DC_INDEX_W     4
`define DC_TAG_W       (32 - `DC_INDEX_W - `DC_OFFSET_W)
`define DC_WSEL_W      (`DC_OFFSET_W - 2)

`endif

//--- verilog/dcache_pkg.sv
`default_nettype none

package dcache_pkg;

    // ******************************
    // Control encodings
    // ******************************
    typedef enum logic [2:0] {
        DC_IDLE,
        DC_LOOKUP,
        DC_MISS,       // Victim writeback request
        DC_REPLACE,    // Refill read request
        DC_REFILL,
        DC_WAIT_WRITE
    } dc_state_e;

    typedef enum logic {
        DC_READ,
        DC_WRITE
    } dc_op_e;

    // ******************************
    // CPU side
    // ******************************
    typedef struct packed {
        dc_op_e      op;
        logic        uncache;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
    } cpu_req_t;

    typedef struct packed {
        logic [31:0] rdata;
    } cpu_rsp_t;

    // ******************************
    // Memory side
    // ******************************
    typedef struct packed {
        logic [31:0] addr;
        logic [1:0]  len;    // Beats minus one
    } mem_rd_req_t;

    typedef struct packed {
        logic [31:0] addr;
        logic [1:0]  len;
    } mem_wr_req_t;

    typedef struct packed {
        logic [31:0] data;
        logic [3:0]  strb;
        logic        last;
    } mem_wr_beat_t;

endpackage

`default_nettype wire

//--- verilog/dcache_main_fsm.sv
`timescale 1ns/10ps
`default_nettype none

module dcache_main_fsm (
    input  wire                    clk,
    input  wire                    rstn,
    input  wire                    cpu_valid,
    input  wire dcache_pkg::dc_op_e req_op,
    input  wire                    req_uncache,
    input  wire                    hit,
    input  wire                    victim_dirty,
    input  wire                    victim_valid,
    input  wire                    rd_rdy,
    input  wire                    wr_rdy,
    input  wire                    fill_done,
    input  wire                    wb_done,
    output logic                   cache_ready,
    output logic                   data_valid,
    output logic                   rd_req,
    output logic                   wr_req,
    output logic                   req_load,
    output logic                   tag_we,
    output logic                   data_we,
    output logic                   refill_we,
    output logic                   sel_refill,
    output logic                   victim_load,
    output logic                   wb_start
);
    import dcache_pkg::*;

    dc_state_e state_q;
    dc_state_e state_d;
    dc_state_e after_retire;   // Where to go once the current request completes
    logic      cached_hit;

    assign cached_hit   = !req_uncache && hit;
    assign after_retire = cpu_valid ? DC_LOOKUP : DC_IDLE;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state_q <= DC_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // ******************************
    // Next state
    // ******************************
    always_comb begin
        state_d = state_q;
        case (state_q)
            DC_IDLE: begin
                if (cpu_valid) begin
                    state_d = DC_LOOKUP;
                end
            end
            DC_LOOKUP: begin
                // Uncached goes first, then hit, then a dirty victim
                if (req_uncache) begin
                    state_d = (req_op == DC_WRITE) ? DC_MISS : DC_REPLACE;
                end else if (hit) begin
                    state_d = after_retire;
                end else if (victim_valid && victim_dirty) begin
                    state_d = DC_MISS;
                end else begin
                    state_d = DC_REPLACE;
                end
            end
            DC_MISS: begin
                if (wr_rdy) begin
                    state_d = req_uncache ? DC_WAIT_WRITE : DC_REPLACE;
                end
            end
            DC_REPLACE: begin
                if (rd_rdy) begin
                    state_d = DC_REFILL;
                end
            end
            DC_REFILL: begin
                if (fill_done) begin
                    state_d = DC_WAIT_WRITE;
                end
            end
            DC_WAIT_WRITE: begin
                if (wb_done) begin
                    state_d = after_retire;
                end
            end
            default: state_d = DC_IDLE;
        endcase
    end

    // ******************************
    // Strobes and requests
    // ******************************
    always_comb begin
        cache_ready = 1'b0;
        data_valid  = 1'b0;
        rd_req      = 1'b0;
        wr_req      = 1'b0;
        tag_we      = 1'b0;
        data_we     = 1'b0;
        refill_we   = 1'b0;
        sel_refill  = 1'b0;
        victim_load = 1'b0;
        wb_start    = 1'b0;
        case (state_q)
            DC_IDLE: cache_ready = 1'b1;
            DC_LOOKUP: begin
                if (cached_hit) begin
                    data_valid  = 1'b1;
                    cache_ready = 1'b1;
                    data_we     = 1'b1;     // Store bytes and LRU update
                end else if (!req_uncache) begin
                    victim_load = 1'b1;     // Grab the victim before the refill lands
                end
            end
            DC_MISS: begin
                wr_req   = 1'b1;
                wb_start = wr_rdy;
            end
            DC_REPLACE: rd_req = 1'b1;
            DC_REFILL: begin
                if (fill_done && !req_uncache) begin
                    refill_we = 1'b1;
                    tag_we    = 1'b1;
                end
            end
            DC_WAIT_WRITE: begin
                sel_refill = 1'b1;
                if (wb_done) begin
                    data_valid  = 1'b1;
                    cache_ready = 1'b1;
                end
            end
            default: cache_ready = 1'b0;
        endcase
        req_load = cache_ready && cpu_valid;
    end

endmodule

`default_nettype wire

//--- verilog/dcache_ways.sv
`timescale 1ns/10ps
`default_nettype none

`include "dcache_defs.svh"

module dcache_ways (
    input  wire                    clk,
    input  wire                    rstn,
    input  wire  [31:0]            addr,
    input  wire  [31:0]            wdata,
    input  wire  [3:0]             wstrb,
    input  wire  [`DC_LINE_W-1:0]  refill_line,
    input  wire                    data_we,
    input  wire                    tag_we,
    input  wire                    refill_we,
    output logic                   hit,
    output logic [31:0]            hit_word,
    output logic                   victim_dirty,
    output logic                   victim_valid,
    output logic [`DC_LINE_W-1:0]  victim_line,
    output logic [31:0]            victim_addr
);
    logic [`DC_TAG_W-1:0]              tag_mem  [`DC_WAYS][`DC_SETS];
    logic [`DC_LINE_W-1:0]             data_mem [`DC_WAYS][`DC_SETS];
    logic [`DC_SETS-1:0][`DC_WAYS-1:0] valid_q;
    logic [`DC_SETS-1:0][`DC_WAYS-1:0] dirty_q;
    logic [`DC_SETS-1:0]               lru_q;     // Names the next victim of each set

    logic [`DC_TAG_W-1:0]   tag;
    logic [`DC_INDEX_W-1:0] idx;
    logic [`DC_WSEL_W-1:0]  word;
    logic [`DC_WAYS-1:0]    way_hit;
    logic                   hit_way;
    logic                   victim_way;

    assign tag  = addr[31 -: `DC_TAG_W];
    assign idx  = addr[`DC_OFFSET_W +: `DC_INDEX_W];
    assign word = addr[`DC_OFFSET_W-1:2];

    always_comb begin
        way_hit = '0;
        for (int w = 0; w < `DC_WAYS; w++) begin
            way_hit[w] = valid_q[idx][w] && (tag_mem[w][idx] == tag);
        end
    end

    assign hit        = |way_hit;
    assign hit_way    = way_hit[1];    // Two ways so the upper hit bit is the way number
    assign victim_way = lru_q[idx];
    assign hit_word   = data_mem[hit_way][idx][word*32 +: 32];

    assign victim_valid = valid_q[idx][victim_way];
    assign victim_dirty = dirty_q[idx][victim_way];
    assign victim_line  = data_mem[victim_way][idx];
    assign victim_addr  = {tag_mem[victim_way][idx], idx, {`DC_OFFSET_W{1'b0}}};

    // ******************************
    // Line state and replacement
    // ******************************
    always_ff @(posedge clk) begin
        if (!rstn) begin
            valid_q <= '0;
            dirty_q <= '0;
            lru_q   <= '0;
        end else if (tag_we) begin
            valid_q[idx][victim_way] <= 1'b1;
            dirty_q[idx][victim_way] <= |wstrb;    // Strobes are zero for reads
            lru_q[idx]               <= ~victim_way;
        end else if (data_we) begin
            dirty_q[idx][hit_way] <= dirty_q[idx][hit_way] | (|wstrb);
            lru_q[idx]            <= ~hit_way;
        end
    end

    always_ff @(posedge clk) begin
        if (tag_we) begin
            tag_mem[victim_way][idx] <= tag;
        end
        if (refill_we) begin
            data_mem[victim_way][idx] <= refill_line;
        end
        if (data_we) begin
            for (int b = 0; b < 4; b++) begin
                if (wstrb[b]) begin
                    data_mem[hit_way][idx][word*32 + b*8 +: 8] <= wdata[b*8 +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/dcache_line_buf.sv
`timescale 1ns/10ps
`default_nettype none

`include "dcache_defs.svh"

module dcache_line_buf (
    input  wire                           clk,
    input  wire                           rstn,
    input  wire  dcache_pkg::cpu_req_t    cpu_req,
    input  wire                           req_load,
    output dcache_pkg::cpu_req_t          req,
    input  wire                           victim_load,
    input  wire  [`DC_LINE_W-1:0]         victim_line,
    input  wire  [31:0]                   victim_addr,
    input  wire                           wb_start,
    input  wire                           rd_beat_valid,
    input  wire                           rd_last,
    input  wire  [31:0]                   rd_data,
    input  wire                           wr_beat_ready,
    input  wire                           wr_done,
    output logic                          wr_beat_valid,
    output dcache_pkg::mem_wr_beat_t      mem_wr_beat,
    output dcache_pkg::mem_wr_req_t       mem_wr_req,
    output dcache_pkg::mem_rd_req_t       mem_rd_req,
    output logic [`DC_LINE_W-1:0]         refill_line,
    output logic                          fill_done,
    output logic                          wb_done
);
    import dcache_pkg::*;

    logic [`DC_LINE_W-1:0] wb_line;
    logic [31:0]           wb_addr;
    logic [`DC_WSEL_W-1:0] wb_cnt;
    logic [`DC_WSEL_W-1:0] fill_cnt;
    logic [1:0]            burst_len;
    logic                  wb_active;    // Beats still to send
    logic                  wb_busy;      // Waiting for wr_done
    logic [31:0]           fill_word;

    always_ff @(posedge clk) begin
        if (req_load) begin
            req       <= cpu_req;
            req.wstrb <= (cpu_req.op == DC_WRITE) ? cpu_req.wstrb : 4'h0;
        end
        if (victim_load) begin
            wb_line <= victim_line;
            wb_addr <= victim_addr;
        end
    end

    assign burst_len = req.uncache ? 2'd0 : 2'(`DC_LINE_WORDS - 1);

    assign mem_rd_req.addr = req.uncache ? {req.addr[31:2], 2'b00}
                                         : {req.addr[31:`DC_OFFSET_W], {`DC_OFFSET_W{1'b0}}};
    assign mem_rd_req.len  = burst_len;
    assign mem_wr_req.addr = req.uncache ? {req.addr[31:2], 2'b00} : wb_addr;
    assign mem_wr_req.len  = burst_len;

    // ******************************
    // Writeback stream
    // ******************************
    assign wr_beat_valid    = wb_active;
    assign wb_done          = !wb_busy;
    assign mem_wr_beat.data = req.uncache ? req.wdata : wb_line[wb_cnt*32 +: 32];
    assign mem_wr_beat.strb = req.uncache ? req.wstrb : 4'hf;
    assign mem_wr_beat.last = (wb_cnt == burst_len);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            wb_active <= 1'b0;
            wb_busy   <= 1'b0;
            wb_cnt    <= '0;
        end else begin
            if (wb_start) begin
                wb_active <= 1'b1;
                wb_busy   <= 1'b1;
                wb_cnt    <= '0;
            end else if (wr_beat_valid && wr_beat_ready) begin
                if (mem_wr_beat.last) begin
                    wb_active <= 1'b0;
                end else begin
                    wb_cnt <= wb_cnt + 1'b1;
                end
            end
            if (wr_done) begin
                wb_busy <= 1'b0;
            end
        end
    end

    // ******************************
    // Refill collector
    // ******************************
    always_comb begin
        fill_word = rd_data;
        if (fill_cnt == req.addr[`DC_OFFSET_W-1:2]) begin
            for (int b = 0; b < 4; b++) begin
                if (req.wstrb[b]) begin
                    fill_word[b*8 +: 8] = req.wdata[b*8 +: 8];   // Write miss merge
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            fill_done <= 1'b0;
            fill_cnt  <= '0;
        end else if (req_load) begin
            fill_done <= 1'b0;
            fill_cnt  <= cpu_req.uncache ? cpu_req.addr[`DC_OFFSET_W-1:2] : '0;
        end else if (rd_beat_valid) begin
            fill_cnt <= fill_cnt + 1'b1;
            if (rd_last) begin
                fill_done <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_beat_valid) begin
            refill_line[fill_cnt*32 +: 32] <= fill_word;
        end
    end

endmodule

`default_nettype wire

//--- verilog/dcache_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "dcache_defs.svh"

module dcache_top (
    input  wire                           clk,
    input  wire                           rstn,
    input  wire                           cpu_valid,
    input  wire  dcache_pkg::cpu_req_t    cpu_req,
    output logic                          cache_ready,
    output logic                          data_valid,
    output dcache_pkg::cpu_rsp_t          cpu_rsp,
    output logic                          rd_req,
    output dcache_pkg::mem_rd_req_t       mem_rd_req,
    input  wire                           rd_rdy,
    input  wire                           rd_beat_valid,
    input  wire                           rd_last,
    input  wire  [31:0]                   rd_data,
    output logic                          wr_req,
    output dcache_pkg::mem_wr_req_t       mem_wr_req,
    output logic                          wr_beat_valid,
    output dcache_pkg::mem_wr_beat_t      mem_wr_beat,
    input  wire                           wr_rdy,
    input  wire                           wr_beat_ready,
    input  wire                           wr_done
);
    import dcache_pkg::*;

    cpu_req_t              req;
    logic                  hit, victim_dirty, victim_valid;
    logic                  fill_done, wb_done;
    logic                  req_load, tag_we, data_we, refill_we;
    logic                  sel_refill, victim_load, wb_start;
    logic [31:0]           hit_word;
    logic [31:0]           victim_addr;
    logic [`DC_LINE_W-1:0] victim_line;
    logic [`DC_LINE_W-1:0] refill_line;

    // Misses and uncached reads answer from the freshly filled line
    assign cpu_rsp.rdata = sel_refill ? refill_line[req.addr[`DC_OFFSET_W-1:2]*32 +: 32]
                                      : hit_word;

    dcache_main_fsm u_fsm (
        .clk          (clk),
        .rstn         (rstn),
        .cpu_valid    (cpu_valid),
        .req_op       (req.op),
        .req_uncache  (req.uncache),
        .hit          (hit),
        .victim_dirty (victim_dirty),
        .victim_valid (victim_valid),
        .rd_rdy       (rd_rdy),
        .wr_rdy       (wr_rdy),
        .fill_done    (fill_done),
        .wb_done      (wb_done),
        .cache_ready  (cache_ready),
        .data_valid   (data_valid),
        .rd_req       (rd_req),
        .wr_req       (wr_req),
        .req_load     (req_load),
        .tag_we       (tag_we),
        .data_we      (data_we),
        .refill_we    (refill_we),
        .sel_refill   (sel_refill),
        .victim_load  (victim_load),
        .wb_start     (wb_start)
    );

    dcache_ways u_ways (
        .clk          (clk),
        .rstn         (rstn),
        .addr         (req.addr),
        .wdata        (req.wdata),
        .wstrb        (req.wstrb),
        .refill_line  (refill_line),
        .data_we      (data_we),
        .tag_we       (tag_we),
        .refill_we    (refill_we),
        .hit          (hit),
        .hit_word     (hit_word),
        .victim_dirty (victim_dirty),
        .victim_valid (victim_valid),
        .victim_line  (victim_line),
        .victim_addr  (victim_addr)
    );

    dcache_line_buf u_line_buf (
        .clk           (clk),
        .rstn          (rstn),
        .cpu_req       (cpu_req),
        .req_load      (req_load),
        .req           (req),
        .victim_load   (victim_load),
        .victim_line   (victim_line),
        .victim_addr   (victim_addr),
        .wb_start      (wb_start),
        .rd_beat_valid (rd_beat_valid),
        .rd_last       (rd_last),
        .rd_data       (rd_data),
        .wr_beat_ready (wr_beat_ready),
        .wr_done       (wr_done),
        .wr_beat_valid (wr_beat_valid),
        .mem_wr_beat   (mem_wr_beat),
        .mem_wr_req    (mem_wr_req),
        .mem_rd_req    (mem_rd_req),
        .refill_line   (refill_line),
        .fill_done     (fill_done),
        .wb_done       (wb_done)
    );

endmodule

`default_nettype wire

//--- bench/dcache_checker.sv
`timescale 1ns/10ps
`default_nettype none

module dcache_checker (
    input  wire                           clk,
    input  wire                           rstn,
    input  wire                           cpu_valid,
    input  wire  dcache_pkg::cpu_req_t    cpu_req,
    input  wire                           cache_ready,
    input  wire                           data_valid,
    input  wire  dcache_pkg::cpu_rsp_t    cpu_rsp,
    input  wire                           expect_hit,
    input  wire                           rd_req,
    input  wire  dcache_pkg::mem_rd_req_t mem_rd_req,
    input  wire                           rd_rdy,
    input  wire                           wr_req,
    input  wire  dcache_pkg::mem_wr_req_t mem_wr_req,
    input  wire                           wr_rdy,
    input  wire                           wr_beat_valid,
    input  wire  dcache_pkg::mem_wr_beat_t mem_wr_beat,
    input  wire                           wr_beat_ready,
    output int                            errors,
    output int                            responses
);
    import dcache_pkg::*;

    logic [31:0] shadow [1024];
    cpu_req_t    pend;
    logic        pend_valid;
    logic        pend_hit;
    logic [31:0] pend_exp;
    int          age;
    int          bursts;
    logic [9:0]  wr_idx;
    logic [1:0]  wr_len;
    logic [1:0]  wr_cnt;

    function automatic logic [31:0] init_word(input logic [9:0] idx);
        return {idx, 22'h0} ^ (32'(idx) * 32'h9e3779b1);
    endfunction

    // What a read of this address must return after every accepted store
    function automatic logic [31:0] expected_word(input logic [31:0] addr);
        return shadow[addr[11:2]];
    endfunction

    initial begin
        for (int i = 0; i < 1024; i++) begin
            shadow[i] = init_word(10'(i));
        end
        errors     = 0;
        responses  = 0;
        pend_valid = 1'b0;
    end

    // ******************************
    // Compare at the falling edge
    // ******************************
    always @(negedge clk) begin
        logic [31:0] mask;
        logic [31:0] line_addr;
        if (rstn) begin
            if (pend_valid) begin
                age = age + 1;
                if ((rd_req && rd_rdy) || (wr_req && wr_rdy)) begin
                    bursts = bursts + 1;
                end
            end
            if (rd_req && rd_rdy) begin
                line_addr = pend.uncache ? {pend.addr[31:2], 2'b00} : {pend.addr[31:4], 4'h0};
                if (!pend_valid) begin
                    $display("Memory read request at %0t with no CPU request outstanding", $time);
                    errors = errors + 1;
                end else if (mem_rd_req.len != (pend.uncache ? 2'd0 : 2'd3) ||
                             mem_rd_req.addr != line_addr) begin
                    $display("Mismatch at %0t: mem_rd_req got %h/%0d expected %h/%0d", $time,
                             mem_rd_req.addr, mem_rd_req.len, line_addr, pend.uncache ? 0 : 3);
                    errors = errors + 1;
                end
            end
            if (wr_req && wr_rdy) begin
                wr_idx = mem_wr_req.addr[11:2];
                wr_len = pend.uncache ? 2'd0 : 2'd3;
                wr_cnt = 2'd0;
                if (mem_wr_req.len != wr_len) begin
                    $display("Mismatch at %0t: mem_wr_req.len got %0d expected %0d", $time,
                             mem_wr_req.len, wr_len);
                    errors = errors + 1;
                end
                if (pend.uncache && mem_wr_req.addr != {pend.addr[31:2], 2'b00}) begin
                    $display("Mismatch at %0t: mem_wr_req.addr got %h expected %h", $time,
                             mem_wr_req.addr, {pend.addr[31:2], 2'b00});
                    errors = errors + 1;
                end else if (!pend.uncache && (mem_wr_req.addr[7:0] != {pend.addr[7:4], 4'h0} ||
                                               mem_wr_req.addr[31:8] == pend.addr[31:8])) begin
                    $display("Writeback at %0t to %h is not another line in the set of %h",
                             $time, mem_wr_req.addr, pend.addr);
                    errors = errors + 1;
                end
            end
            if (wr_beat_valid && wr_beat_ready) begin
                mask = {{8{mem_wr_beat.strb[3]}}, {8{mem_wr_beat.strb[2]}},
                        {8{mem_wr_beat.strb[1]}}, {8{mem_wr_beat.strb[0]}}};
                if (((mem_wr_beat.data ^ shadow[wr_idx]) & mask) != 32'h0) begin
                    $display("Mismatch at %0t: mem_wr_beat.data got %h expected %h", $time,
                             mem_wr_beat.data & mask, shadow[wr_idx] & mask);
                    errors = errors + 1;
                end
                if (mem_wr_beat.strb != (pend.uncache ? pend.wstrb : 4'hf)) begin
                    $display("Mismatch at %0t: mem_wr_beat.strb got %h expected %h", $time,
                             mem_wr_beat.strb, pend.uncache ? pend.wstrb : 4'hf);
                    errors = errors + 1;
                end
                if (mem_wr_beat.last != (wr_cnt == wr_len)) begin
                    $display("Mismatch at %0t: mem_wr_beat.last got %b expected %b", $time,
                             mem_wr_beat.last, wr_cnt == wr_len);
                    errors = errors + 1;
                end
                wr_idx = wr_idx + 10'd1;
                wr_cnt = wr_cnt + 2'd1;
            end
            if (data_valid) begin
                if (!pend_valid) begin
                    $display("Response at %0t with no request outstanding", $time);
                    errors = errors + 1;
                end else begin
                    responses = responses + 1;
                    if (pend.op == DC_READ && cpu_rsp.rdata !== pend_exp) begin
                        $display("Mismatch at %0t: cpu_rsp.rdata got %h expected %h", $time,
                                 cpu_rsp.rdata, pend_exp);
                        errors = errors + 1;
                    end
                    if (pend_hit && (age != 1 || bursts != 0)) begin
                        $display("Expected hit at address %h took %0d cycles and %0d bursts",
                                 pend.addr, age, bursts);
                        errors = errors + 1;
                    end
                end
                pend_valid = 1'b0;
            end
            if (cpu_valid && cache_ready) begin
                pend       = cpu_req;
                pend_valid = 1'b1;
                pend_hit   = expect_hit;
                age        = 0;
                bursts     = 0;
                if (cpu_req.op == DC_READ) begin
                    pend_exp = expected_word(cpu_req.addr);
                end else begin
                    for (int b = 0; b < 4; b++) begin
                        if (cpu_req.wstrb[b]) begin
                            shadow[cpu_req.addr[11:2]][b*8 +: 8] = cpu_req.wdata[b*8 +: 8];
                        end
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- bench/tb_dcache.sv
`timescale 1ns/10ps
`default_nettype none

module tb_dcache;
    import dcache_pkg::*;

    localparam int N_DIRECTED     = 12;
    localparam int N_RANDOM       = 300;
    localparam int TIMEOUT_CYCLES = 200 * (N_DIRECTED + N_RANDOM);

    logic         clk;
    logic         rstn;
    logic         cpu_valid;
    cpu_req_t     cpu_req;
    logic         cache_ready;
    logic         data_valid;
    cpu_rsp_t     cpu_rsp;
    logic         expect_hit;
    logic         rd_req;
    mem_rd_req_t  mem_rd_req;
    logic         rd_rdy;
    logic         rd_beat_valid;
    logic         rd_last;
    logic [31:0]  rd_data;
    logic         wr_req;
    mem_wr_req_t  mem_wr_req;
    logic         wr_beat_valid;
    mem_wr_beat_t mem_wr_beat;
    logic         wr_rdy;
    logic         wr_beat_ready;
    logic         wr_done;
    int           errors;
    int           responses;
    int           issued;
    int           cycles;
    integer       seed;

    logic [31:0] mem [1024];
    logic        rd_busy;
    logic [31:0] rd_addr;
    logic [1:0]  rd_len;
    logic [1:0]  rd_cnt;
    logic [1:0]  rd_wait;
    logic        wr_busy;
    logic [9:0]  wr_idx;

    dcache_top uut (.*);

    dcache_checker chk (.*);

    // Same pattern as the checker's shadow, spread over all ten index bits
    function automatic logic [31:0] init_word(input logic [9:0] idx);
        return {idx, 22'h0} ^ (32'(idx) * 32'h9e3779b1);
    endfunction

    always #20 clk = ~clk;

    // ******************************
    // Memory model
    // ******************************
    always @(posedge clk) begin
        rd_beat_valid <= 1'b0;
        rd_last       <= 1'b0;
        if (!rstn) begin
            rd_rdy  <= 1'b0;
            rd_busy <= 1'b0;
        end else if (rd_busy) begin
            if (rd_wait != 2'd0) begin
                rd_wait <= rd_wait - 2'd1;             // Random latency before the data
            end else begin
                rd_beat_valid <= 1'b1;
                rd_data       <= mem[rd_addr[11:2] + 10'(rd_cnt)];
                rd_last       <= (rd_cnt == rd_len);
                rd_cnt        <= rd_cnt + 2'd1;
                if (rd_cnt == rd_len) begin
                    rd_busy <= 1'b0;
                end
            end
        end else if (rd_req && rd_rdy) begin
            rd_busy <= 1'b1;
            rd_rdy  <= 1'b0;
            rd_addr <= mem_rd_req.addr;
            rd_len  <= mem_rd_req.len;
            rd_cnt  <= 2'd0;
            rd_wait <= 2'($random(seed));
        end else begin
            rd_rdy <= 1'($random(seed));
        end
    end

    always @(posedge clk) begin
        wr_done <= 1'b0;
        if (!rstn) begin
            wr_rdy        <= 1'b0;
            wr_beat_ready <= 1'b0;
            wr_busy       <= 1'b0;
        end else if (wr_busy) begin
            wr_beat_ready <= 1'($random(seed));
            if (wr_beat_valid && wr_beat_ready) begin
                for (int b = 0; b < 4; b++) begin
                    if (mem_wr_beat.strb[b]) begin
                        mem[wr_idx][b*8 +: 8] <= mem_wr_beat.data[b*8 +: 8];
                    end
                end
                wr_idx <= wr_idx + 10'd1;
                if (mem_wr_beat.last) begin
                    wr_busy       <= 1'b0;
                    wr_done       <= 1'b1;
                    wr_beat_ready <= 1'b0;
                end
            end
        end else if (wr_req && wr_rdy) begin
            wr_busy <= 1'b1;
            wr_rdy  <= 1'b0;
            wr_idx  <= mem_wr_req.addr[11:2];
        end else begin
            wr_rdy <= 1'($random(seed));
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("*** FAILED ***");
            $finish;
        end
    end

    // ******************************
    // Stimulus
    // ******************************
    task automatic send_req(input dc_op_e op, input logic unc, input logic [31:0] addr,
                            input logic [31:0] wdata, input logic [3:0] wstrb,
                            input logic hit_exp);
        @(posedge clk);
        cpu_valid  <= 1'b1;
        cpu_req    <= '{op: op, uncache: unc, addr: addr, wdata: wdata, wstrb: wstrb};
        expect_hit <= hit_exp;
        do begin
            @(negedge clk);
        end while (!cache_ready);                      // Accepted on the next edge
        @(posedge clk);
        cpu_valid <= 1'b0;
        issued    = issued + 1;
    endtask

    initial begin
        logic [31:0] addr;
        logic [3:0]  strb;
        logic        unc;
        seed          = 32'h3b3a;
        clk           = 1'b0;
        rstn          = 1'b0;
        cpu_valid     = 1'b0;
        cpu_req       = '0;
        expect_hit    = 1'b0;
        rd_rdy        = 1'b0;
        rd_beat_valid = 1'b0;
        rd_last       = 1'b0;
        rd_data       = '0;
        wr_rdy        = 1'b0;
        wr_beat_ready = 1'b0;
        wr_done       = 1'b0;
        issued        = 0;
        cycles        = 0;
        for (int i = 0; i < 1024; i++) begin
            mem[i] = init_word(10'(i));
        end
        repeat (3) @(posedge clk);
        rstn <= 1'b1;

        send_req(DC_READ, 1'b0, 32'h040, 32'h0, 4'h0, 1'b0);           // Cold miss
        send_req(DC_READ, 1'b0, 32'h044, 32'h0, 4'h0, 1'b1);
        send_req(DC_WRITE, 1'b0, 32'h048, 32'hdeadbeef, 4'b0101, 1'b1); // Write hit
        send_req(DC_READ, 1'b0, 32'h048, 32'h0, 4'h0, 1'b1);
        send_req(DC_WRITE, 1'b0, 32'h154, 32'hcafef00d, 4'b1100, 1'b0); // Write miss
        send_req(DC_READ, 1'b0, 32'h154, 32'h0, 4'h0, 1'b1);
        send_req(DC_READ, 1'b0, 32'h140, 32'h0, 4'h0, 1'b0);
        send_req(DC_READ, 1'b0, 32'h240, 32'h0, 4'h0, 1'b0);           // Evicts dirty 0x040
        send_req(DC_READ, 1'b0, 32'h048, 32'h0, 4'h0, 1'b0);
        send_req(DC_READ, 1'b1, 32'h800, 32'h0, 4'h0, 1'b0);
        send_req(DC_WRITE, 1'b1, 32'h804, 32'h12345678, 4'b0110, 1'b0);
        send_req(DC_READ, 1'b1, 32'h804, 32'h0, 4'h0, 1'b0);

        // Uncached traffic stays in its own region so no cached copy goes stale
        for (int n = 0; n < N_RANDOM; n++) begin
            unc  = (2'($random(seed)) == 2'd0);
            addr = unc ? (32'h800 | (32'($random(seed)) & 32'h3c))
                       : (32'($random(seed)) & 32'h3fc);
            strb = 4'($random(seed));
            if (strb == 4'h0) begin
                strb = 4'hf;
            end
            send_req(dc_op_e'(1'($random(seed))), unc, addr, 32'($random(seed)), strb, 1'b0);
        end

        while (responses != issued) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);
        $display("Summary: %0d requests, %0d responses, %0d errors", issued, responses, errors);
        if (errors == 0 && responses == issued) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
+incdir+verilog
verilog/dcache_pkg.sv
verilog/dcache_main_fsm.sv
verilog/dcache_ways.sv
verilog/dcache_line_buf.sv
verilog/dcache_top.sv
bench/dcache_checker.sv
bench/tb_dcache.sv

//--- Makefile
LOG = sim.log

.PHONY: all run lint clean

all: run

obj_dir/Vtb_dcache: files.f $(wildcard verilog/*) $(wildcard bench/*)
	verilator --binary --timing -f files.f --top-module tb_dcache

run: obj_dir/Vtb_dcache
	./obj_dir/Vtb_dcache | tee $(LOG)
	grep -q '^\*\*\* PASSED \*\*\*$$' $(LOG)

lint:
	verilator --lint-only --timing -f files.f --top-module tb_dcache

clean:
	rm -rf obj_dir $(LOG)
